// File: rtl/fifo_hexdump_pkg.sv
`default_nettype none

package fifo_hexdump_pkg;

    // page buffer geometry
    localparam int BUF_BIT_AW  = 13;                  // 8 k bits
    localparam int BUF_BYTE_AW = 10;                  // 1 k bytes
    localparam int TEXT_AW     = 7;                   // 128 byte text rom

    // control characters
    localparam logic [7:0] CHAR_CR    = 8'h0D;
    localparam logic [7:0] CHAR_LF    = 8'h0A;
    localparam logic [7:0] CHAR_SPACE = 8'h20;

    // nibble to ascii table, first character at the msb end
    localparam logic [16*8-1:0] HEX_DIGITS = "0123456789ABCDEF";

    // boot title carries its own line end, hex lines follow directly
    localparam logic [32*8-1:0] BOOT_TITLE = {
        "BUBBLE MEMORY BOOT LOADER DUMP",
        CHAR_CR,
        CHAR_LF
    };

    // user title is followed by the page number digits
    localparam logic [12*8-1:0] USER_TITLE = "USER PAGE 0x";

    // rom map
    localparam logic [6:0] BOOT_TITLE_ADDR = 7'd16;   // right after the hex digits
    localparam logic [6:0] USER_TITLE_ADDR = 7'd80;
    localparam logic [7:0] BOOT_TITLE_LEN  = 8'd32;
    localparam logic [7:0] USER_TITLE_LEN  = 8'd12;

    // buffer byte, seen whole or as two hex digits
    typedef union packed {
        logic [7:0]      raw;
        logic [1:0][3:0] nibble;                      // [1] is the high digit, sent first
    } dump_byte_u;

endpackage

`default_nettype wire

// File: rtl/sipo_buffer.sv
`timescale 1ns/1ns
`default_nettype none

module sipo_buffer (
    input  wire                                   MCLK,
    input  wire                                   buf_wr_en_n,
    input  wire  [fifo_hexdump_pkg::BUF_BIT_AW-1:0]  buf_wr_addr,
    input  wire                                   buf_wr_bit,
    input  wire                                   rd_en,
    input  wire  [fifo_hexdump_pkg::BUF_BYTE_AW-1:0] rd_addr,
    output logic [7:0]                            rd_data
);

    import fifo_hexdump_pkg::*;

    logic [7:0] mem [2**BUF_BYTE_AW];                  // one page, byte organised

    // serial side, bit address 0 lands on the msb of byte 0
    always_ff @(posedge MCLK) begin
        if (!buf_wr_en_n) begin
            mem[buf_wr_addr[BUF_BIT_AW-1:3]][3'd7 - buf_wr_addr[2:0]] <= buf_wr_bit;
        end
    end

    // host side, registered byte read
    always_ff @(posedge MCLK) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

`default_nettype wire

// File: rtl/text_rom.sv
`timescale 1ns/1ns
`default_nettype none

module text_rom (
    input  wire                               MCLK,
    input  wire                               text_rd,
    input  wire  [fifo_hexdump_pkg::TEXT_AW-1:0] text_addr,
    output logic [7:0]                        text_data
);

    import fifo_hexdump_pkg::*;

    localparam int ROM_BITS = 8 << TEXT_AW;

    // entry n sits at bits [8n+7:8n]
    function automatic logic [ROM_BITS-1:0] build_image();
        logic [ROM_BITS-1:0] img;
        img = {(2**TEXT_AW){CHAR_SPACE}};              // unused entries print as blanks
        for (int i = 0; i < 16; i++) begin
            img[8*i +: 8] = HEX_DIGITS[8*(15-i) +: 8];
        end
        for (int i = 0; i < int'(BOOT_TITLE_LEN); i++) begin
            img[8*(int'(BOOT_TITLE_ADDR) + i) +: 8] =
                BOOT_TITLE[8*(int'(BOOT_TITLE_LEN) - 1 - i) +: 8];
        end
        for (int i = 0; i < int'(USER_TITLE_LEN); i++) begin
            img[8*(int'(USER_TITLE_ADDR) + i) +: 8] =
                USER_TITLE[8*(int'(USER_TITLE_LEN) - 1 - i) +: 8];
        end
        return img;
    endfunction

    localparam logic [ROM_BITS-1:0] ROM_IMAGE = build_image();

    always_ff @(posedge MCLK) begin
        if (text_rd) begin
            text_data <= ROM_IMAGE[{text_addr, 3'b000} +: 8];
        end
    end

endmodule

`default_nettype wire

// File: rtl/fifo_writer.sv
`timescale 1ns/1ns
`default_nettype none

module fifo_writer (
    input  wire        MCLK,
    input  wire        rst,
    input  wire        tx_req,
    input  wire  [7:0] tx_data,
    input  wire        txe_n,
    output logic       tx_ack,
    output logic [7:0] fifo_data,
    output logic       wr_n
);

    import fifo_hexdump_pkg::*;

    localparam logic [1:0] W_IDLE    = 2'd0;
    localparam logic [1:0] W_STROBE  = 2'd1;
    localparam logic [1:0] W_RELEASE = 2'd2;

    logic [1:0] state;

    always_ff @(posedge MCLK) begin
        if (rst) begin
            state     <= W_IDLE;
            wr_n      <= 1'b1;
            tx_ack    <= 1'b0;
            fifo_data <= CHAR_SPACE;
        end else begin
            tx_ack <= 1'b0;
            case (state)
                W_IDLE: begin
                    // ack cycle blocks a second write of the same character
                    if (tx_req && !txe_n && !tx_ack) begin
                        fifo_data <= tx_data;             // held until the next strobe
                        wr_n      <= 1'b0;
                        state     <= W_STROBE;
                    end
                end
                W_STROBE: begin
                    state <= W_RELEASE;                   // second low cycle
                end
                W_RELEASE: begin
                    wr_n   <= 1'b1;
                    tx_ack <= 1'b1;                       // same cycle wr_n goes high
                    state  <= W_IDLE;
                end
                default: begin
                    wr_n  <= 1'b1;
                    state <= W_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: rtl/message_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

module message_sequencer #(
    parameter int BOOT_LINES     = 30,
    parameter int USER_LINES     = 8,
    parameter int BYTES_PER_LINE = 16
) (
    input  wire                                   MCLK,
    input  wire                                   rst,
    input  wire                                   send_boot_n,
    input  wire                                   send_user_n,
    input  wire                                   fifo_en_n,
    input  wire  [11:0]                           rel_page,
    output logic                                  rd_en,
    output logic [fifo_hexdump_pkg::BUF_BYTE_AW-1:0] rd_addr,
    input  wire  [7:0]                            rd_data,
    output logic                                  text_rd,
    output logic [fifo_hexdump_pkg::TEXT_AW-1:0]     text_addr,
    input  wire  [7:0]                            text_data,
    output logic                                  tx_req,
    output logic [7:0]                            tx_data,
    input  wire                                   tx_ack
);

    import fifo_hexdump_pkg::*;

    localparam int MAX_LINES = (BOOT_LINES > USER_LINES) ? BOOT_LINES : USER_LINES;
    localparam int LINE_W    = $clog2(MAX_LINES + 1);
    localparam int CNT_W     = (BYTES_PER_LINE > 255) ? $clog2(BYTES_PER_LINE + 1) : 8;

    localparam logic [3:0] S_IDLE   = 4'd0;
    localparam logic [3:0] S_TITLE  = 4'd1;            // title character loop
    localparam logic [3:0] S_TROM   = 4'd2;            // text rom read cycle
    localparam logic [3:0] S_TCHAR  = 4'd3;            // rom data to tx register
    localparam logic [3:0] S_SEND   = 4'd4;            // wait for the writer
    localparam logic [3:0] S_PAGE   = 4'd5;            // page number digits
    localparam logic [3:0] S_LINE   = 4'd6;            // line loop
    localparam logic [3:0] S_BYTE   = 4'd7;            // byte loop
    localparam logic [3:0] S_BRD    = 4'd8;            // buffer read cycle
    localparam logic [3:0] S_BLOAD  = 4'd9;
    localparam logic [3:0] S_HI     = 4'd10;
    localparam logic [3:0] S_LO     = 4'd11;
    localparam logic [3:0] S_SP     = 4'd12;
    localparam logic [3:0] S_EOL_CR = 4'd13;
    localparam logic [3:0] S_EOL_LF = 4'd14;
    localparam logic [3:0] S_DONE   = 4'd15;

    logic [3:0]        state;
    logic [3:0]        ret_state;                      // where S_SEND returns to
    logic [3:0]        eol_next;                       // where the line end returns to
    logic              boot_mode;
    logic [CNT_W-1:0]  cnt;                            // characters, digits or bytes left
    logic [LINE_W-1:0] lines;
    logic [11:0]       page_r;
    dump_byte_u        byte_r;

    assign rd_en   = (state == S_BRD);
    assign text_rd = (state == S_TROM);

    always_ff @(posedge MCLK) begin
        if (rst) begin
            state     <= S_IDLE;
            ret_state <= S_IDLE;
            eol_next  <= S_IDLE;
            boot_mode <= 1'b0;
            cnt       <= '0;
            lines     <= '0;
            rd_addr   <= '0;
            text_addr <= '0;
            tx_req    <= 1'b0;
        end else if (send_boot_n && send_user_n) begin
            // both requests released, drop everything
            state  <= S_IDLE;
            tx_req <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (!fifo_en_n) begin
                        boot_mode <= !send_boot_n;                  // boot wins
                        text_addr <= !send_boot_n ? BOOT_TITLE_ADDR : USER_TITLE_ADDR;
                        cnt       <= !send_boot_n ? CNT_W'(BOOT_TITLE_LEN)
                                                  : CNT_W'(USER_TITLE_LEN);
                        page_r    <= rel_page;
                        rd_addr   <= '0;
                        state     <= S_TITLE;
                    end
                end
                S_TITLE: begin
                    if (cnt == '0) begin
                        if (boot_mode) begin
                            lines <= LINE_W'(BOOT_LINES);
                            state <= S_LINE;
                        end else begin
                            lines <= LINE_W'(USER_LINES);
                            cnt   <= CNT_W'(3);                     // three page digits
                            state <= S_PAGE;
                        end
                    end else begin
                        cnt       <= cnt - CNT_W'(1);
                        ret_state <= S_TITLE;
                        state     <= S_TROM;
                    end
                end
                S_TROM: begin
                    state <= S_TCHAR;
                end
                S_TCHAR: begin
                    tx_data   <= text_data;
                    tx_req    <= 1'b1;
                    text_addr <= text_addr + 1'b1;                  // next title character
                    state     <= S_SEND;
                end
                S_SEND: begin
                    if (tx_ack) begin
                        tx_req <= 1'b0;
                        state  <= ret_state;
                    end
                end
                S_PAGE: begin
                    if (cnt == '0) begin
                        eol_next <= S_LINE;
                        state    <= S_EOL_CR;
                    end else begin
                        text_addr <= TEXT_AW'(page_r[11:8]);        // high digit first
                        page_r    <= {page_r[7:0], 4'h0};
                        cnt       <= cnt - CNT_W'(1);
                        ret_state <= S_PAGE;
                        state     <= S_TROM;
                    end
                end
                S_LINE: begin
                    if (lines == '0) begin
                        eol_next <= S_DONE;                         // closing blank line
                        state    <= S_EOL_CR;
                    end else begin
                        lines <= lines - LINE_W'(1);
                        cnt   <= CNT_W'(BYTES_PER_LINE);
                        state <= S_BYTE;
                    end
                end
                S_BYTE: begin
                    if (cnt == '0) begin
                        eol_next <= S_LINE;
                        state    <= S_EOL_CR;
                    end else begin
                        cnt   <= cnt - CNT_W'(1);
                        state <= S_BRD;
                    end
                end
                S_BRD: begin
                    state <= S_BLOAD;
                end
                S_BLOAD: begin
                    byte_r.raw <= rd_data;
                    rd_addr    <= rd_addr + 1'b1;
                    state      <= S_HI;
                end
                S_HI: begin
                    text_addr <= TEXT_AW'(byte_r.nibble[1]);
                    ret_state <= S_LO;
                    state     <= S_TROM;
                end
                S_LO: begin
                    text_addr <= TEXT_AW'(byte_r.nibble[0]);
                    ret_state <= S_SP;
                    state     <= S_TROM;
                end
                S_SP: begin
                    tx_data   <= CHAR_SPACE;
                    tx_req    <= 1'b1;
                    ret_state <= S_BYTE;
                    state     <= S_SEND;
                end
                S_EOL_CR: begin
                    tx_data   <= CHAR_CR;
                    tx_req    <= 1'b1;
                    ret_state <= S_EOL_LF;
                    state     <= S_SEND;
                end
                S_EOL_LF: begin
                    tx_data   <= CHAR_LF;
                    tx_req    <= 1'b1;
                    ret_state <= eol_next;
                    state     <= S_SEND;
                end
                S_DONE: begin
                    state <= S_DONE;                                // left only by release
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: rtl/fifo_hexdump_top.sv
`timescale 1ns/1ns
`default_nettype none

module fifo_hexdump_top #(
    parameter int BOOT_LINES     = 30,
    parameter int USER_LINES     = 8,
    parameter int BYTES_PER_LINE = 16
) (
    input  wire                                  MCLK,
    input  wire                                  rst,
    input  wire                                  buf_wr_en_n,
    input  wire  [fifo_hexdump_pkg::BUF_BIT_AW-1:0] buf_wr_addr,
    input  wire                                  buf_wr_bit,
    input  wire                                  send_boot_n,
    input  wire                                  send_user_n,
    input  wire  [11:0]                          rel_page,
    input  wire                                  fifo_en_n,
    input  wire                                  txe_n,
    output logic [7:0]                           fifo_data,
    output logic                                 wr_n
);

    import fifo_hexdump_pkg::*;

    // buffer read port
    logic                   rd_en;
    logic [BUF_BYTE_AW-1:0] rd_addr;
    logic [7:0]             rd_data;

    // text rom port
    logic                   text_rd;
    logic [TEXT_AW-1:0]     text_addr;
    logic [7:0]             text_data;

    // character handshake to the writer
    logic                   tx_req;
    logic [7:0]             tx_data;
    logic                   tx_ack;

    sipo_buffer u_sipo_buffer (
        .MCLK        (MCLK),
        .buf_wr_en_n (buf_wr_en_n),
        .buf_wr_addr (buf_wr_addr),
        .buf_wr_bit  (buf_wr_bit),
        .rd_en       (rd_en),
        .rd_addr     (rd_addr),
        .rd_data     (rd_data)
    );

    text_rom u_text_rom (
        .MCLK      (MCLK),
        .text_rd   (text_rd),
        .text_addr (text_addr),
        .text_data (text_data)
    );

    message_sequencer #(
        .BOOT_LINES     (BOOT_LINES),
        .USER_LINES     (USER_LINES),
        .BYTES_PER_LINE (BYTES_PER_LINE)
    ) u_message_sequencer (
        .MCLK        (MCLK),
        .rst         (rst),
        .send_boot_n (send_boot_n),
        .send_user_n (send_user_n),
        .fifo_en_n   (fifo_en_n),
        .rel_page    (rel_page),
        .rd_en       (rd_en),
        .rd_addr     (rd_addr),
        .rd_data     (rd_data),
        .text_rd     (text_rd),
        .text_addr   (text_addr),
        .text_data   (text_data),
        .tx_req      (tx_req),
        .tx_data     (tx_data),
        .tx_ack      (tx_ack)
    );

    fifo_writer u_fifo_writer (
        .MCLK      (MCLK),
        .rst       (rst),
        .tx_req    (tx_req),
        .tx_data   (tx_data),
        .txe_n     (txe_n),
        .tx_ack    (tx_ack),
        .fifo_data (fifo_data),
        .wr_n      (wr_n)
    );

endmodule

`default_nettype wire

// File: verif/fifo_hexdump_asserts.sv
`timescale 1ns/1ns
`default_nettype none

module fifo_hexdump_asserts (
    input wire       MCLK,
    input wire       rst,
    input wire       txe_n,
    input wire       wr_n,
    input wire [7:0] fifo_data
);

    // a strobe only starts when the fifo showed space at the edge before
    strobe_needs_space: assert property (
        @(posedge MCLK) disable iff (rst)
        $fell(wr_n) |-> !$past(txe_n)
    ) else $error("wr_n fell although txe_n was high in the previous cycle");

    strobe_min_width: assert property (
        @(posedge MCLK) disable iff (rst)
        $fell(wr_n) |=> !wr_n                          // second low cycle
    ) else $error("wr_n low for only one cycle");

    strobe_max_width: assert property (
        @(posedge MCLK) disable iff (rst)
        (!wr_n && !$past(wr_n)) |=> wr_n               // no third low cycle
    ) else $error("wr_n low for more than two cycles");

    data_stable: assert property (
        @(posedge MCLK) disable iff (rst)
        !wr_n |=> $stable(fifo_data)
    ) else $error("fifo_data changed while wr_n was low");

endmodule

bind fifo_hexdump_top fifo_hexdump_asserts u_asserts (
    .MCLK      (MCLK),
    .rst       (rst),
    .txe_n     (txe_n),
    .wr_n      (wr_n),
    .fifo_data (fifo_data)
);

`default_nettype wire

// File: verif/tb_fifo_hexdump.sv
`timescale 1ns/1ns
`default_nettype none

module tb_fifo_hexdump;

    import fifo_hexdump_pkg::*;

    localparam int BOOT_LINES      = 30;
    localparam int USER_LINES      = 8;
    localparam int BYTES_PER_LINE  = 16;
    localparam int LINE_CHARS      = 3 * BYTES_PER_LINE + 2;
    localparam int BOOT_CHARS      = int'(BOOT_TITLE_LEN) + BOOT_LINES * LINE_CHARS + 2;
    localparam int USER_CHARS      = int'(USER_TITLE_LEN) + 5 + USER_LINES * LINE_CHARS + 2;
    localparam int ALL_CHARS       = 2 * BOOT_CHARS + 4 * USER_CHARS;  // two boot, four user runs
    localparam int CYCLES_PER_CHAR = 24;                               // worst case with back-pressure
    localparam int FILL_CYCLES     = 2**BUF_BIT_AW;
    localparam int WATCHDOG_CYCLES = 2 * ALL_CHARS * CYCLES_PER_CHAR + FILL_CYCLES + 1000;

    logic                  MCLK = 1'b0;
    logic                  rst;
    logic                  buf_wr_en_n;
    logic [BUF_BIT_AW-1:0] buf_wr_addr;
    logic                  buf_wr_bit;
    logic                  send_boot_n;
    logic                  send_user_n;
    logic [11:0]           rel_page;
    logic                  fifo_en_n;
    logic                  txe_n;
    logic [7:0]            fifo_data;
    logic                  wr_n;

    logic [7:0] byte_model [2**BUF_BYTE_AW];            // what the serial fill wrote
    logic [7:0] expect_q [$];                           // characters still due from the DUT
    logic [7:0] exp_char;
    logic       wr_prev = 1'b1;
    logic       bp_on = 1'b0;
    logic       txe_next;
    int         strobe_cnt = 0;

    fifo_hexdump_top #(
        .BOOT_LINES     (BOOT_LINES),
        .USER_LINES     (USER_LINES),
        .BYTES_PER_LINE (BYTES_PER_LINE)
    ) UUT (
        .MCLK        (MCLK),
        .rst         (rst),
        .buf_wr_en_n (buf_wr_en_n),
        .buf_wr_addr (buf_wr_addr),
        .buf_wr_bit  (buf_wr_bit),
        .send_boot_n (send_boot_n),
        .send_user_n (send_user_n),
        .rel_page    (rel_page),
        .fifo_en_n   (fifo_en_n),
        .txe_n       (txe_n),
        .fifo_data   (fifo_data),
        .wr_n        (wr_n)
    );

    always #20 MCLK = ~MCLK;

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic step(input int n);
        repeat (n) @(posedge MCLK);
        #2;
    endtask

    function automatic logic [7:0] hex_char(input logic [3:0] n);
        return (n < 4'd10) ? 8'h30 + {4'h0, n} : 8'h41 + {4'h0, n} - 8'd10;
    endfunction

    task automatic push_text(input logic [255:0] text, input int len);
        for (int i = 0; i < len; i++) begin
            expect_q.push_back(text[8*(len-1-i) +: 8]);   // first character at the top
        end
    endtask

    task automatic push_eol();
        expect_q.push_back(8'h0D);
        expect_q.push_back(8'h0A);
    endtask

    // hex lines from byte 0 upward, then the closing line end
    task automatic push_lines(input int n);
        int idx;
        idx = 0;
        for (int l = 0; l < n; l++) begin
            for (int b = 0; b < BYTES_PER_LINE; b++) begin
                expect_q.push_back(hex_char(byte_model[idx][7:4]));
                expect_q.push_back(hex_char(byte_model[idx][3:0]));
                expect_q.push_back(8'h20);
                idx++;
            end
            push_eol();
        end
        push_eol();
    endtask

    task automatic queue_boot();
        push_text(256'(BOOT_TITLE), int'(BOOT_TITLE_LEN));
        push_lines(BOOT_LINES);
    endtask

    task automatic queue_user(input logic [11:0] page);
        push_text(256'(USER_TITLE), int'(USER_TITLE_LEN));
        expect_q.push_back(hex_char(page[11:8]));
        expect_q.push_back(hex_char(page[7:4]));
        expect_q.push_back(hex_char(page[3:0]));
        push_eol();
        push_lines(USER_LINES);
    endtask

    task automatic fill_buffer();
        logic b;
        for (int a = 0; a < FILL_CYCLES; a++) begin
            b = 1'($urandom);
            buf_wr_en_n = 1'b0;
            buf_wr_addr = BUF_BIT_AW'(a);
            buf_wr_bit  = b;
            byte_model[a / 8][7 - (a % 8)] = b;          // bit 0 is the msb of byte 0
            step(1);
        end
        buf_wr_en_n = 1'b1;
    endtask

    task automatic wait_drained();
        while (expect_q.size() != 0) step(1);
    endtask

    task automatic finish_dump();
        step(10);                                       // stray strobes in done are caught here
        send_boot_n = 1'b1;
        send_user_n = 1'b1;
        step(5);
    endtask

    // fifo host model, every falling wr_n takes one character
    always @(negedge MCLK) begin
        if (!rst && wr_prev && wr_n === 1'b0) begin
            strobe_cnt++;
            assert (expect_q.size() != 0)
                else fail_run("write strobe seen while no character was due");
            exp_char = expect_q.pop_front();
            assert (fifo_data === exp_char)
                else fail_run($sformatf("ERROR fifo_data: got 0x%02h, expected 0x%02h",
                                        fifo_data, exp_char));
        end
        wr_prev = wr_n;
    end

    // drawn at the edge and applied with the input delay
    always @(posedge MCLK) begin
        txe_next = bp_on ? (($urandom % 2) == 1) : 1'b0;  // random fifo full
        #2;
        txe_n = txe_next;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge MCLK);
        fail_run("watchdog expired before all dumps finished");
    end

    initial begin
        int target;
        void'($urandom(32'hf0b17843));
        rst         = 1'b1;
        buf_wr_en_n = 1'b1;
        buf_wr_addr = '0;
        buf_wr_bit  = 1'b0;
        send_boot_n = 1'b1;
        send_user_n = 1'b1;
        rel_page    = '0;
        fifo_en_n   = 1'b0;
        txe_n       = 1'b0;
        step(8);
        rst = 1'b0;
        fill_buffer();

        // quiet after reset
        repeat (20) begin
            @(negedge MCLK);
            assert (wr_n === 1'b1)
                else fail_run($sformatf("ERROR wr_n: got 0x%0h, expected 0x1", wr_n));
            assert (fifo_data === 8'h20)
                else fail_run($sformatf("ERROR fifo_data: got 0x%02h, expected 0x20",
                                        fifo_data));
        end
        step(1);

        queue_boot();
        send_boot_n = 1'b0;
        wait_drained();
        finish_dump();

        rel_page = 12'($urandom);
        queue_user(rel_page);
        send_user_n = 1'b0;
        wait_drained();
        finish_dump();

        bp_on = 1'b1;
        queue_boot();
        send_boot_n = 1'b0;
        wait_drained();
        finish_dump();
        bp_on = 1'b0;

        // cancel mid-dump, a strobe may still start at the first edge
        rel_page = 12'($urandom);
        queue_user(rel_page);
        send_user_n = 1'b0;
        target = strobe_cnt + 30;
        while (strobe_cnt < target) step(1);
        send_user_n = 1'b1;
        step(2);
        expect_q.delete();
        step(20);
        queue_user(rel_page);
        send_user_n = 1'b0;
        wait_drained();
        finish_dump();

        // held off by fifo_en_n
        fifo_en_n   = 1'b1;
        rel_page    = 12'($urandom);
        send_user_n = 1'b0;
        step(40);
        queue_user(rel_page);
        fifo_en_n = 1'b0;
        wait_drained();
        finish_dump();

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
rtl/fifo_hexdump_pkg.sv
rtl/sipo_buffer.sv
rtl/text_rom.sv
rtl/fifo_writer.sv
rtl/message_sequencer.sv
rtl/fifo_hexdump_top.sv
verif/fifo_hexdump_asserts.sv
verif/tb_fifo_hexdump.sv

// File: Makefile
TOP = tb_fifo_hexdump

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert -Wno-fatal \
		-f sources.f --top-module $(TOP) -o V$(TOP)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
